/* lat_defs.svh */
`ifndef LAT_DEFS_SVH
`define LAT_DEFS_SVH

// fetch group shape
`define LAT_LANES       4
`define LAT_ADDR_W      16

// counters, unroll budget and table sizing
`define LAT_CNT_W       7
`define LAT_DEPTH       4

// fetch stalls once this many instructions went out of the loop buffer
`define LAT_STALL_LIMIT 64

// longest body that still gets an unroll budget
`define LAT_MAX_BODY    64

`endif

/* lat_pkg.sv */
`default_nettype none

`include "lat_defs.svh"

package lat_pkg;

   typedef logic [`LAT_ADDR_W-1:0]        addr_t;      // one lane's pc
   typedef logic [`LAT_CNT_W-1:0]         cnt_t;       // instruction count / unroll
   typedef logic [`LAT_LANES-1:0]         lane_mask_t; // msb is lane 0
   typedef logic [$clog2(`LAT_DEPTH)-1:0] ptr_t;       // table slot

   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      TRAIN    = 2'd1,
      DISPATCH = 2'd2
   } lbd_state_e;

   // lanes whose pc is the loop branch (fall-through minus one)
   function automatic lane_mask_t end_lanes(input addr_t pcs [`LAT_LANES], input addr_t ft);
      lane_mask_t e;
      e = '0;
      for (int i = 0; i < `LAT_LANES; i++) begin
         e[`LAT_LANES-1-i] = (pcs[i] == addr_t'(ft - 1'b1));
      end
      return e;
   endfunction

   // lane 0 up to and including the first end lane, all lanes if none
   function automatic lane_mask_t valid_lanes(input lane_mask_t e);
      lane_mask_t m;
      logic seen;
      m = '0;
      seen = 1'b0;
      for (int i = `LAT_LANES-1; i >= 0; i--) begin
         m[i] = !seen;
         seen = seen | e[i];
      end
      return m;
   endfunction

   function automatic cnt_t lane_cnt(input lane_mask_t m);
      cnt_t c;
      c = '0;
      for (int i = 0; i < `LAT_LANES; i++) begin
         c = c + cnt_t'(m[i]);
      end
      return c;
   endfunction

endpackage

`default_nettype wire

/* lat_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// trainer to table, one write per committed loop
interface lat_wr_if;
   logic                wr_en;       // single cycle pulse
   lat_pkg::addr_t      start;
   lat_pkg::addr_t      fallthrough;
   lat_pkg::cnt_t       count;
   lat_pkg::cnt_t       unroll;

   modport source (
      output wr_en, start, fallthrough, count, unroll
   );

   modport sink (
      input wr_en, start, fallthrough, count, unroll
   );
endinterface

// table lookup result for lane 0 of the current group
interface lat_hit_if;
   logic                hit;
   lat_pkg::addr_t      hit_fallthrough;
   lat_pkg::cnt_t       hit_unroll;
   lat_pkg::ptr_t       hit_slot;    // lowest matching slot

   modport source (
      output hit, hit_fallthrough, hit_unroll, hit_slot
   );

   modport receiver (
      input hit, hit_fallthrough, hit_unroll, hit_slot
   );
endinterface

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lat_defs.svh"

module fetch_stage (
   input  wire logic                                   clk,
   input  wire logic                                   rst,
   input  wire logic [`LAT_LANES*`LAT_ADDR_W-1:0]      pc_group,
   input  lat_pkg::lane_mask_t                         bck_lp,
   input  lat_pkg::lane_mask_t                         branch_take,
   output lat_pkg::addr_t                              lane_pc [`LAT_LANES],
   output lat_pkg::lane_mask_t                         bk_mask,
   output lat_pkg::addr_t                              bk_pc
);

   // only taken backward branches count
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bk_mask <= '0;
      end else begin
         bk_mask <= bck_lp & branch_take;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `LAT_LANES; i++) begin
         lane_pc[i] <= pc_group[(`LAT_LANES-i)*`LAT_ADDR_W-1 -: `LAT_ADDR_W]; // lane 0 on top
      end
   end

   // pc of the oldest flagged lane, walk from the youngest so lane 0 wins
   always_comb begin
      bk_pc = lane_pc[0];
      for (int i = `LAT_LANES-1; i >= 0; i--) begin
         if (bk_mask[`LAT_LANES-1-i]) bk_pc = lane_pc[i];
      end
   end

endmodule

`default_nettype wire

/* lat_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lat_ctrl (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           bk_any,
   input  wire logic           end_train,
   lat_hit_if.receiver         hit,
   input  wire logic           mis_pred,
   output logic                capture_ft,
   output logic                train_en,
   output logic                commit,
   output logic                load_loop,
   output logic                dispatching,
   output logic                loop_strt,
   output lat_pkg::lbd_state_e lbd_state
);

   lat_pkg::lbd_state_e state_q;
   lat_pkg::lbd_state_e state_d;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= lat_pkg::IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d    = state_q;
      capture_ft = 1'b0;
      train_en   = 1'b0;
      commit     = 1'b0;
      load_loop  = hit.hit && (state_q != lat_pkg::DISPATCH); // hit only counts outside dispatch

      case (state_q)
         lat_pkg::IDLE: begin
            if (load_loop) begin
               state_d = lat_pkg::DISPATCH;
            end else if (bk_any) begin
               capture_ft = 1'b1;                            // latch fall-through now
               state_d    = lat_pkg::TRAIN;
            end
         end
         lat_pkg::TRAIN: begin
            if (load_loop) begin
               state_d = lat_pkg::DISPATCH;                  // known loop wins over training
            end else begin
               train_en = 1'b1;
               if (end_train) begin
                  commit  = 1'b1;
                  state_d = lat_pkg::IDLE;
               end
            end
         end
         lat_pkg::DISPATCH: begin
            if (mis_pred) state_d = lat_pkg::IDLE;
         end
         default: state_d = lat_pkg::IDLE;
      endcase
   end

   assign loop_strt   = load_loop;
   assign dispatching = (state_q == lat_pkg::DISPATCH);
   assign lbd_state   = state_q;

   // a running loop must not be reloaded from the table
   a_no_reload: assert property (@(posedge clk) disable iff (rst)
      dispatching |-> !load_loop)
      else $error("lat_ctrl: loop start during dispatch");

   a_commit_vs_load: assert property (@(posedge clk) disable iff (rst)
      !(commit && load_loop))
      else $error("lat_ctrl: commit overlapped a loop start");

endmodule

`default_nettype wire

/* loop_trainer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lat_defs.svh"

module loop_trainer (
   input  wire logic      clk,
   input  wire logic      rst,
   input  lat_pkg::addr_t lane_pc [`LAT_LANES],
   input  lat_pkg::addr_t bk_pc,
   input  wire logic      capture_ft,
   input  wire logic      train_en,
   input  wire logic      commit,
   output logic           end_train,
   lat_wr_if.source       wr
);

   lat_pkg::addr_t          ft_q;
   lat_pkg::addr_t          start_q;
   lat_pkg::cnt_t           cnt_q;
   lat_pkg::lane_mask_t     end_vec;
   lat_pkg::cnt_t           grp_cnt;
   logic [`LAT_CNT_W:0]     sum;        // one extra bit for saturation
   logic                    wr_q;

   assign end_vec   = lat_pkg::end_lanes(lane_pc, ft_q);
   assign end_train = |end_vec;
   assign grp_cnt   = lat_pkg::lane_cnt(lat_pkg::valid_lanes(end_vec));
   assign sum       = cnt_q + grp_cnt;

   always_ff @(posedge clk) begin
      if (capture_ft) ft_q <= bk_pc + 1'b1;              // branch pc plus one
      if (train_en && cnt_q == '0) start_q <= lane_pc[0]; // first body group
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt_q <= '0;
         wr_q  <= 1'b0;
      end else begin
         wr_q <= commit;                                  // write one cycle after commit
         if (capture_ft) begin
            cnt_q <= '0;
         end else if (train_en) begin
            cnt_q <= sum[`LAT_CNT_W] ? '1 : sum[`LAT_CNT_W-1:0];
         end
      end
   end

   assign wr.wr_en       = wr_q;
   assign wr.start       = start_q;
   assign wr.fallthrough = ft_q;
   assign wr.count       = cnt_q;
   assign wr.unroll      = (cnt_q != '0 && cnt_q <= `LAT_MAX_BODY) ? 7'd1 : 7'd0;

   a_nonzero_body: assert property (@(posedge clk) disable iff (rst)
      wr.wr_en |-> wr.count != '0)
      else $error("loop_trainer: empty loop body committed");

endmodule

`default_nettype wire

/* lat_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lat_defs.svh"

module lat_table (
   input  wire logic      clk,
   input  wire logic      rst,
   input  lat_pkg::addr_t lane0_pc,
   lat_wr_if.sink         wr,
   lat_hit_if.source      hit
);

   logic [`LAT_DEPTH-1:0] vld_q;
   lat_pkg::addr_t        start_q [`LAT_DEPTH];
   lat_pkg::addr_t        ft_q    [`LAT_DEPTH];
   lat_pkg::cnt_t         cnt_q   [`LAT_DEPTH];
   lat_pkg::cnt_t         unrl_q  [`LAT_DEPTH];
   lat_pkg::ptr_t         ptr_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vld_q <= '0;
         ptr_q <= '0;
      end else if (wr.wr_en) begin
         vld_q[ptr_q] <= 1'b1;
         ptr_q        <= ptr_q + 1'b1; // round robin, oldest slot goes next
      end
   end

   always_ff @(posedge clk) begin
      if (wr.wr_en) begin
         start_q[ptr_q] <= wr.start;
         ft_q[ptr_q]    <= wr.fallthrough;
         cnt_q[ptr_q]   <= wr.count;
         unrl_q[ptr_q]  <= wr.unroll;
      end
   end

   // start address lookup, lowest slot wins
   always_comb begin
      hit.hit      = 1'b0;
      hit.hit_slot = '0;
      for (int i = `LAT_DEPTH-1; i >= 0; i--) begin
         if (vld_q[i] && start_q[i] == lane0_pc) begin
            hit.hit      = 1'b1;
            hit.hit_slot = lat_pkg::ptr_t'(i);
         end
      end
   end

   assign hit.hit_fallthrough = ft_q[hit.hit_slot];
   assign hit.hit_unroll      = unrl_q[hit.hit_slot];

   // entry behind a hit was written by a real commit
   a_hit_valid: assert property (@(posedge clk) disable iff (rst)
      hit.hit |-> vld_q[hit.hit_slot] && cnt_q[hit.hit_slot] != '0)
      else $error("lat_table: hit on an empty or invalid slot");

endmodule

`default_nettype wire

/* dispatch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lat_defs.svh"

module dispatch_unit (
   input  wire logic           clk,
   input  wire logic           rst,
   input  lat_pkg::addr_t      lane_pc [`LAT_LANES],
   lat_hit_if.receiver         hit,
   input  wire logic           load_loop,
   input  wire logic           dispatching,
   output lat_pkg::lane_mask_t inst_valid,
   output logic                stll_ftch,
   output logic                fnsh_unrll
);

   lat_pkg::addr_t      ft_q;       // active loop fall-through
   lat_pkg::addr_t      act_ft;
   lat_pkg::cnt_t       rem_q;      // unroll left
   lat_pkg::cnt_t       stl_q;      // dispatched instructions
   lat_pkg::cnt_t       stl_sum;
   lat_pkg::cnt_t       grp_cnt;
   lat_pkg::lane_mask_t end_vec;
   lat_pkg::lane_mask_t mask;
   logic                end_any;

   // table values straight through in the loop start cycle
   assign act_ft  = load_loop ? hit.hit_fallthrough : ft_q;
   assign end_vec = lat_pkg::end_lanes(lane_pc, act_ft);
   assign end_any = |end_vec;
   assign mask    = lat_pkg::valid_lanes(end_vec);
   assign grp_cnt = lat_pkg::lane_cnt(mask);
   assign stl_sum = (load_loop ? '0 : stl_q) + grp_cnt; // max 68, fits

   always_ff @(posedge clk) begin
      if (load_loop) ft_q <= hit.hit_fallthrough;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rem_q <= '0;
         stl_q <= '0;
      end else if (load_loop) begin
         // start group is the first dispatched group
         rem_q <= (end_any && hit.hit_unroll != '0) ? hit.hit_unroll - 1'b1 : hit.hit_unroll;
         stl_q <= (stl_sum > `LAT_STALL_LIMIT) ? 7'(`LAT_STALL_LIMIT) : stl_sum;
      end else if (dispatching) begin
         if (end_any && rem_q != '0) rem_q <= rem_q - 1'b1;
         stl_q <= (stl_sum > `LAT_STALL_LIMIT) ? 7'(`LAT_STALL_LIMIT) : stl_sum;
      end else begin
         rem_q <= '0;
         stl_q <= '0;
      end
   end

   assign inst_valid = (load_loop || dispatching) ? mask : '1;
   assign stll_ftch  = dispatching && (stl_q == `LAT_STALL_LIMIT);
   assign fnsh_unrll = dispatching && (rem_q == '0);

   a_stall_sat: assert property (@(posedge clk) disable iff (rst)
      stl_q <= `LAT_STALL_LIMIT)
      else $error("dispatch_unit: stall counter past limit");

endmodule

`default_nettype wire

/* lat_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lat_defs.svh"

module lat_top (
   input  wire logic                              clk,
   input  wire logic                              rst,
   input  wire logic [`LAT_LANES*`LAT_ADDR_W-1:0] pc_group,
   input  wire logic [`LAT_LANES-1:0]             bck_lp,
   input  wire logic [`LAT_LANES-1:0]             branch_take,
   input  wire logic                              mis_pred,
   output logic [1:0]                             lbd_state,
   output logic                                   loop_strt,
   output logic [`LAT_LANES-1:0]                  inst_valid,
   output logic                                   stll_ftch,
   output logic                                   fnsh_unrll
);

   lat_pkg::addr_t      lane_pc [`LAT_LANES];
   lat_pkg::lane_mask_t bk_mask;
   lat_pkg::addr_t      bk_pc;
   lat_pkg::lbd_state_e state;
   logic                end_train;
   logic                capture_ft;
   logic                train_en;
   logic                commit;
   logic                load_loop;
   logic                dispatching;

   lat_wr_if  wr_if ();
   lat_hit_if hit_if ();

   fetch_stage i_fetch_stage (
      .clk         (clk),
      .rst         (rst),
      .pc_group    (pc_group),
      .bck_lp      (bck_lp),
      .branch_take (branch_take),
      .lane_pc     (lane_pc),
      .bk_mask     (bk_mask),
      .bk_pc       (bk_pc)
   );

   lat_ctrl i_lat_ctrl (
      .clk         (clk),
      .rst         (rst),
      .bk_any      (|bk_mask),
      .end_train   (end_train),
      .hit         (hit_if.receiver),
      .mis_pred    (mis_pred),
      .capture_ft  (capture_ft),
      .train_en    (train_en),
      .commit      (commit),
      .load_loop   (load_loop),
      .dispatching (dispatching),
      .loop_strt   (loop_strt),
      .lbd_state   (state)
   );

   loop_trainer i_loop_trainer (
      .clk        (clk),
      .rst        (rst),
      .lane_pc    (lane_pc),
      .bk_pc      (bk_pc),
      .capture_ft (capture_ft),
      .train_en   (train_en),
      .commit     (commit),
      .end_train  (end_train),
      .wr         (wr_if.source)
   );

   lat_table i_lat_table (
      .clk      (clk),
      .rst      (rst),
      .lane0_pc (lane_pc[0]),
      .wr       (wr_if.sink),
      .hit      (hit_if.source)
   );

   dispatch_unit i_dispatch_unit (
      .clk         (clk),
      .rst         (rst),
      .lane_pc     (lane_pc),
      .hit         (hit_if.receiver),
      .load_loop   (load_loop),
      .dispatching (dispatching),
      .inst_valid  (inst_valid),
      .stll_ftch   (stll_ftch),
      .fnsh_unrll  (fnsh_unrll)
   );

   assign lbd_state = state;

endmodule

`default_nettype wire

/* tb_lat_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lat_defs.svh"

module tb_lat_top;

   localparam int          CLK_PERIOD = 100;
   localparam int          RESET_CYC  = 5;
   localparam int          TRAIN_CYC  = 24;   // trigger, up to 20 body groups, filler
   localparam int          DISP_CYC   = 24;   // one pass of the longest body plus exit
   localparam int          STALL_CYC  = 80;
   localparam int          TOTAL_CYC  = RESET_CYC + 10 + 7*TRAIN_CYC + STALL_CYC + 3*DISP_CYC + 20;
   localparam int          MARGIN_CYC = 200;
   localparam int          TIMEOUT_NS = (TOTAL_CYC + MARGIN_CYC) * CLK_PERIOD;
   localparam logic [15:0] FILLER     = 16'hF200; // region never used by a loop

   logic                                  clk;
   logic                                  rst;
   logic [`LAT_LANES*`LAT_ADDR_W-1:0]     pc_group;
   logic [`LAT_LANES-1:0]                 bck_lp;
   logic [`LAT_LANES-1:0]                 branch_take;
   logic                                  mis_pred;
   logic [1:0]                            lbd_state;
   logic                                  loop_strt;
   logic [`LAT_LANES-1:0]                 inst_valid;
   logic                                  stll_ftch;
   logic                                  fnsh_unrll;

   string       test_name;
   logic [31:0] lfsr_q;
   int          region_q;
   int          n_strt;    // loop_strt pulses seen
   int          n_stall;   // cycles with stll_ftch

   // reference model state as it stands after the last rising edge
   logic [63:0] m_grp;
   logic [3:0]  m_bk;
   logic [1:0]  m_state;
   logic [15:0] t_ft;
   logic [15:0] t_start;
   int          t_cnt;
   bit          t_wr;
   bit          tab_vld   [4];
   logic [15:0] tab_start [4];
   logic [15:0] tab_ft    [4];
   int          tab_unr   [4];
   int          tab_ptr;
   logic [15:0] d_ft;
   int          d_rem;
   int          d_stl;

   lat_top i_lat_top (
      .clk         (clk),
      .rst         (rst),
      .pc_group    (pc_group),
      .bck_lp      (bck_lp),
      .branch_take (branch_take),
      .mis_pred    (mis_pred),
      .lbd_state   (lbd_state),
      .loop_strt   (loop_strt),
      .inst_valid  (inst_valid),
      .stll_ftch   (stll_ftch),
      .fnsh_unrll  (fnsh_unrll)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic int unsigned rand_bits(input int n);
      int unsigned r;
      r = 0;
      for (int i = 0; i < n; i++) begin
         r = (r << 1) | lfsr_q[0];
         lfsr_q = lfsr_step(lfsr_q);
      end
      return r;
   endfunction

   // lanes 0 up to the lane holding ft-1 or all four when none does
   function automatic logic [3:0] lat_ref_mask(input logic [63:0] grp, input logic [15:0] ft,
                                               output int n, output bit has_end);
      logic [15:0] br;
      logic [3:0]  m;
      int          end_lane;
      br = ft - 16'd1;
      end_lane = -1;
      for (int i = 0; i < 4; i++) begin
         if (end_lane < 0 && grp[63-16*i -: 16] == br) end_lane = i;
      end
      has_end = (end_lane >= 0);
      n = has_end ? end_lane + 1 : 4;
      m = 4'b0000;
      for (int i = 0; i < n; i++) begin
         m[3-i] = 1'b1;   // bit 3 is lane 0
      end
      return m;
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else begin
         $display("ERR %s: %s expected %0h actual %0h", test_name, what, exp, act);
         $display("Checks failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic drive_group(input logic [15:0] p0, input logic [3:0] bk, input logic [3:0] bt,
                              input logic mp);
      @(posedge clk);
      pc_group    <= {p0, p0 + 16'd1, p0 + 16'd2, p0 + 16'd3};
      bck_lp      <= bk;
      branch_take <= bt;
      mis_pred    <= mp;
   endtask

   task automatic fill_group(input logic mp);
      drive_group(FILLER, 4'b0000, 4'b0000, mp);
   endtask

   // trigger group with the branch in a random lane followed by the body and one filler
   task automatic train_loop(input int len, output logic [15:0] s);
      logic [15:0] b;
      int          lane;
      s = 16'(region_q << 12) + 16'h0010 + 16'(rand_bits(10));
      region_q++;
      b = s + 16'(len - 1);
      lane = rand_bits(2);
      drive_group(b - 16'(lane), (4'b1000 >> lane) | 4'(rand_bits(4)), 4'b1000 >> lane, 1'b0);
      for (int k = 0; k < (len + 3) / 4; k++) begin
         drive_group(s + 16'(4 * k), 4'b0000, 4'b0000, 1'b0);
      end
      fill_group(1'b0);   // table write lands here
   endtask

   task automatic dispatch_pass(input logic [15:0] s, input int len);
      for (int k = 0; k < (len + 3) / 4; k++) begin
         drive_group(s + 16'(4 * k), 4'b0000, 4'b0000, 1'b0);
      end
   endtask

   task automatic leave_dispatch();
      fill_group(1'b1);
      fill_group(1'b0);
      fill_group(1'b0);
   endtask

   // checks outputs against the model and then advances the model
   always @(negedge clk) begin : compare
      logic [15:0] lane0;
      logic [15:0] act_ft;
      logic [15:0] bk_pc;
      logic [3:0]  e_mask;
      logic [1:0]  n_state;
      int          e_n;
      int          t_n;
      int          slot;
      bit          e_end;
      bit          t_end;
      bit          hit;
      bit          load;
      bit          cap;
      bit          ten;
      bit          com;
      if (rst) begin
         m_state = 2'd0;
         t_cnt   = 0;
         t_wr    = 1'b0;
         tab_ptr = 0;
         d_rem   = 0;
         d_stl   = 0;
         for (int i = 0; i < 4; i++) tab_vld[i] = 1'b0;
      end
      lane0 = m_grp[63:48];
      hit = 1'b0;
      slot = 0;
      for (int i = 3; i >= 0; i--) begin
         if (tab_vld[i] && tab_start[i] == lane0) begin
            hit = 1'b1;
            slot = i;
         end
      end
      load = hit && (m_state != 2'd2);
      act_ft = load ? tab_ft[slot] : d_ft;   // hit entry's own fall-through on loop start
      e_mask = lat_ref_mask(m_grp, act_ft, e_n, e_end);

      check_value("lbd_state", m_state, lbd_state);
      check_value("loop_strt", load, loop_strt);
      check_value("inst_valid", (load || m_state == 2'd2) ? e_mask : 4'hF, inst_valid);
      check_value("stll_ftch", (m_state == 2'd2) && (d_stl == 64), stll_ftch);
      check_value("fnsh_unrll", (m_state == 2'd2) && (d_rem == 0), fnsh_unrll);
      if (loop_strt) n_strt++;
      if (stll_ftch) n_stall++;

      if (!rst) begin
         void'(lat_ref_mask(m_grp, t_ft, t_n, t_end));
         bk_pc = lane0;
         for (int i = 3; i >= 0; i--) begin
            if (m_bk[3-i]) bk_pc = m_grp[63-16*i -: 16];
         end
         cap = 1'b0;
         ten = 1'b0;
         com = 1'b0;
         n_state = m_state;
         case (m_state)
            2'd0: begin
               if (load) n_state = 2'd2;
               else if (|m_bk) begin
                  cap = 1'b1;
                  n_state = 2'd1;
               end
            end
            2'd1: begin
               if (load) n_state = 2'd2;
               else begin
                  ten = 1'b1;
                  if (t_end) begin
                     com = 1'b1;
                     n_state = 2'd0;
                  end
               end
            end
            default: if (mis_pred) n_state = 2'd0;   // raw input rather than the registered group
         endcase
         if (t_wr) begin
            tab_vld[tab_ptr]   = 1'b1;
            tab_start[tab_ptr] = t_start;
            tab_ft[tab_ptr]    = t_ft;
            tab_unr[tab_ptr]   = (t_cnt >= 1 && t_cnt <= 64) ? 1 : 0;
            tab_ptr = (tab_ptr + 1) % 4;
         end
         t_wr = com;
         if (cap) begin
            t_ft = bk_pc + 16'd1;
            t_cnt = 0;
         end else if (ten) begin
            if (t_cnt == 0) t_start = lane0;
            t_cnt = (t_cnt + t_n > 127) ? 127 : t_cnt + t_n;
         end
         if (load) begin
            d_ft  = tab_ft[slot];
            d_rem = (e_end && tab_unr[slot] != 0) ? tab_unr[slot] - 1 : tab_unr[slot];
            d_stl = (e_n > 64) ? 64 : e_n;
         end else if (m_state == 2'd2) begin
            if (e_end && d_rem != 0) d_rem--;
            d_stl = (d_stl + e_n > 64) ? 64 : d_stl + e_n;
         end else begin
            d_rem = 0;
            d_stl = 0;
         end
         m_state = n_state;
      end
      m_grp = pc_group;
      m_bk  = rst ? 4'b0000 : (bck_lp & branch_take);
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("timeout in test %s after %0d cycles, the run did not finish",
               test_name, TOTAL_CYC + MARGIN_CYC);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

   initial begin : stimulus
      logic [15:0] s_a;
      logic [15:0] s_b;
      logic [15:0] s_rr [5];
      int          len_a;
      int          len_b;
      int          n0;
      clk         = 1'b0;
      rst         = 1'b1;
      pc_group    = '0;
      bck_lp      = '0;
      branch_take = '0;
      mis_pred    = 1'b0;
      lfsr_q      = 32'd83811;
      region_q    = 1;
      n_strt      = 0;
      n_stall     = 0;
      test_name   = "reset";
      repeat (RESET_CYC) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_value("reset state", lat_pkg::IDLE, lbd_state);
      check_value("reset inst_valid", 4'hF, inst_valid);
      check_value("reset flags", 3'b000, {loop_strt, stll_ftch, fnsh_unrll});

      test_name = "idle";
      drive_group(FILLER, 4'hF, 4'h0, 1'b0);          // backward but not taken
      drive_group(FILLER + 16'd16, 4'h0, 4'hF, 1'b0); // taken but not backward
      fill_group(1'b0);
      fill_group(1'b0);
      @(negedge clk);
      check_value("state after plain groups", lat_pkg::IDLE, lbd_state);

      test_name = "train_hit";
      len_a = 1 + rand_bits(6);
      train_loop(len_a, s_a);
      drive_group(s_a, 4'b0000, 4'b0000, 1'b0);
      drive_group(s_a + 16'd4, 4'b0000, 4'b0000, 1'b0);
      @(negedge clk);
      check_value("loop start pulse", 1'b1, loop_strt);
      drive_group(s_a + 16'd8, 4'b0000, 4'b0000, 1'b0);
      @(negedge clk);
      check_value("state after start", lat_pkg::DISPATCH, lbd_state);
      check_value("single pulse", 1'b0, loop_strt);

      test_name = "lane_mask";
      for (int i = 0; i < 4; i++) begin
         drive_group(s_a + 16'(len_a - 1 - i), 4'b0000, 4'b0000, 1'b0); // end lane i
      end
      fill_group(1'b0);   // no end lane

      test_name = "stall";
      for (int it = 0; it < 64 / len_a + 2; it++) begin
         dispatch_pass(s_a, len_a);
      end
      check_value("stall seen", 1'b1, n_stall != 0);
      leave_dispatch();

      test_name = "long_body";
      len_b = 65 + rand_bits(4);
      train_loop(len_b, s_b);
      drive_group(s_b, 4'b0000, 4'b0000, 1'b0);
      drive_group(s_b + 16'd4, 4'b0000, 4'b0000, 1'b0);
      @(negedge clk);
      check_value("long loop start", 1'b1, loop_strt);
      drive_group(s_b + 16'd8, 4'b0000, 4'b0000, 1'b0);
      @(negedge clk);
      check_value("no unroll budget", 1'b1, fnsh_unrll);
      dispatch_pass(s_b, len_b);
      leave_dispatch();

      test_name = "round_robin";
      for (int j = 0; j < 5; j++) begin
         train_loop(1 + rand_bits(5), s_rr[j]);
      end
      n0 = n_strt;
      drive_group(s_rr[0], 4'b0000, 4'b0000, 1'b0);
      fill_group(1'b0);
      fill_group(1'b0);
      check_value("evicted start hits", n0, n_strt);

      test_name = "mis_pred";
      drive_group(s_rr[4], 4'b0000, 4'b0000, 1'b0);
      fill_group(1'b0);
      @(negedge clk);
      check_value("newest entry hits", 1'b1, loop_strt);
      fill_group(1'b1);   // mispredict while in dispatch
      @(negedge clk);
      check_value("state before flush", lat_pkg::DISPATCH, lbd_state);
      fill_group(1'b0);
      @(negedge clk);
      check_value("state after flush", lat_pkg::IDLE, lbd_state);
      fill_group(1'b0);
      fill_group(1'b0);

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* lat_loop_unroll.f */
+incdir+.
lat_pkg.sv
lat_ifs.sv
fetch_stage.sv
lat_ctrl.sv
loop_trainer.sv
lat_table.sv
dispatch_unit.sv
lat_top.sv
tb_lat_top.sv
